// ==== nes_bus_pkg.sv ====
package nes_bus_pkg;

  typedef logic [15:0] cpu_addr_t;  // cpu address bus
  typedef logic [7:0]  byte_t;      // cpu data byte

  typedef logic [3:0]  axil_addr_t; // debug register byte offset
  typedef logic [31:0] axil_data_t; // axi-lite data word

  // cpu memory map regions, decoded on a[15:13]
  typedef enum logic [1:0] {
    region_wram,                    // 0x0000-0x1fff
    region_ppu,                     // 0x2000-0x3fff, nothing behind it here
    region_io,                      // 0x4000-0x7fff
    region_cart                     // 0x8000-0xffff
  } region_e;

  // host bus-cycle fsm
  typedef enum logic [1:0] {
    dbg_idle,                       // waiting for aw+w or ar
    dbg_bus,                        // host owns one bus cycle
    dbg_resp                        // b or r held until ready
  } dbg_state_e;

  localparam axil_addr_t dbg_ctrl_off = 4'h0; // bit 0 halt
  localparam axil_addr_t dbg_addr_off = 4'h4; // cpu address for host cycles
  localparam axil_addr_t dbg_data_off = 4'h8; // access runs a bus cycle
  localparam axil_addr_t dbg_cfg_off  = 4'hC; // bit 0 set means 32k prg

endpackage

// ==== cpu_bus_if.sv ====
`timescale 1ns/100ps

interface cpu_bus_if import nes_bus_pkg::*; ();

  cpu_addr_t a;           // muxed address
  logic      r_nw;        // 1 read, 0 write
  byte_t     wdata;       // muxed write data
  byte_t     rdata;       // or of the target shares
  logic      wram_en;     // a[15:13] == 000
  logic      cart_en;     // a[15] set
  logic      host_wr;     // host write into prg space
  byte_t     wram_rdata;  // wram share, zero when not selected
  byte_t     cart_rdata;  // cart share, zero when not selected

  modport master (output a, r_nw, wdata, input rdata);
  modport mem_map (output a, r_nw, wdata, rdata, wram_en, cart_en, host_wr,
                   input wram_rdata, cart_rdata);
  modport target (input a, r_nw, wdata, wram_en, cart_en, host_wr,
                  output wram_rdata, cart_rdata);

endinterface

// ==== cpu_mem_map.sv ====
`timescale 1ns/100ps

module cpu_mem_map import nes_bus_pkg::*; (
  input  logic       clk_in,
  input  logic       rst_n,
  input  cpu_addr_t  cpu_a,        // from external cpu
  input  logic       cpu_r_nw,
  input  byte_t      cpu_d_out,
  output byte_t      cpu_d_in,     // valid one cycle after cpu_a
  output logic       cpu_rdy,      // low while host holds the bus
  input  logic       host_active,
  input  cpu_addr_t  host_a,
  input  logic       host_r_nw,
  input  byte_t      host_wdata,
  output byte_t      host_rdata,
  cpu_bus_if.mem_map bus
);

  region_e region;                 // region of the current address
  region_e region_q;               // region of last cycle, matches read latency

  // bus master select, host wins while halted
  assign cpu_rdy   = !host_active;
  assign bus.a     = host_active ? host_a     : cpu_a;
  assign bus.r_nw  = host_active ? host_r_nw  : cpu_r_nw;
  assign bus.wdata = host_active ? host_wdata : cpu_d_out;

  always_comb begin
    casez (bus.a[15:13])
      3'b000:  region = region_wram;
      3'b001:  region = region_ppu;  // ppu regs, mirrored every 8 bytes
      3'b01?:  region = region_io;   // apu, joypads, expansion
      default: region = region_cart;
    endcase
  end

  assign bus.wram_en = (region == region_wram);
  assign bus.cart_en = (region == region_cart);
  assign bus.host_wr = host_active && !host_r_nw && bus.cart_en; // cpu can't write prg

  always_ff @(posedge clk_in) begin
    if (!rst_n) begin
      region_q <= region_io;       // nothing selected
    end else begin
      region_q <= region;
    end
  end

  // wired-or read bus, unselected regions contribute zero
  assign bus.rdata = ((region_q == region_wram) ? bus.wram_rdata : 8'h00) |
                     ((region_q == region_cart) ? bus.cart_rdata : 8'h00);

  assign cpu_d_in   = bus.rdata;
  assign host_rdata = bus.rdata;   // host sees the same byte as the cpu

endmodule

// ==== wram.sv ====
`timescale 1ns/100ps

module wram import nes_bus_pkg::*; (
  input  logic      clk_in,
  cpu_bus_if.target bus
);

  byte_t      mem [2048];          // 2k internal work ram
  logic [10:0] wa;                 // a[12:11] dropped, 4x mirror

  assign wa = bus.a[10:0];

  always_ff @(posedge clk_in) begin
    if (bus.wram_en && !bus.r_nw) begin
      mem[wa] <= bus.wdata;        // write lands at this edge
    end
  end

  // registered read share, zero next cycle when not selected
  always_ff @(posedge clk_in) begin
    if (bus.wram_en) begin
      bus.wram_rdata <= mem[wa];   // old data on read-during-write
    end else begin
      bus.wram_rdata <= 8'h00;
    end
  end

endmodule

// ==== cart_prg.sv ====
`timescale 1ns/100ps

module cart_prg import nes_bus_pkg::*; #(
  parameter int PRG_ADDR_BITS = 15  // 15 for 32k, 14 for 16k only
) (
  input  logic      clk_in,
  input  logic      prg_32k,        // 0 folds 0xc000 onto 0x8000
  cpu_bus_if.target bus
);

  localparam int PRG_BYTES = 1 << PRG_ADDR_BITS;

  byte_t                    prg_mem [PRG_BYTES]; // prg rom image, host loaded
  logic [PRG_ADDR_BITS-1:0] prg_a;               // array index after mirroring

  generate
    if (PRG_ADDR_BITS == 15) begin : g_prg_32k
      assign prg_a = {bus.a[14] & prg_32k, bus.a[13:0]}; // 16k game mirrors upper bank
    end else begin : g_prg_16k
      assign prg_a = bus.a[13:0];                        // a[14] always ignored
    end
  endgenerate

  // host-only writes, cpu stores to prg space are dropped
  always_ff @(posedge clk_in) begin
    if (bus.cart_en && bus.host_wr) begin
      prg_mem[prg_a] <= bus.wdata;
    end
  end

  always_ff @(posedge clk_in) begin
    if (bus.cart_en) begin
      bus.cart_rdata <= prg_mem[prg_a];  // one cycle latency like wram
    end else begin
      bus.cart_rdata <= 8'h00;           // share off the or-bus
    end
  end

endmodule

// ==== dbg_axil_port.sv ====
`timescale 1ns/100ps

module dbg_axil_port import nes_bus_pkg::*; (
  input  logic       clk_in,
  input  logic       rst_n,
  input  axil_addr_t awaddr,
  input  logic       awvalid,
  output logic       awready,
  input  axil_data_t wdata,
  input  logic       wvalid,
  output logic       wready,
  output logic [1:0] bresp,
  output logic       bvalid,
  input  logic       bready,
  input  axil_addr_t araddr,
  input  logic       arvalid,
  output logic       arready,
  output axil_data_t rdata,
  output logic [1:0] rresp,
  output logic       rvalid,
  input  logic       rready,
  output logic       host_active,   // halt, stalls the cpu
  output cpu_addr_t  host_a,
  output logic       host_r_nw,
  output byte_t      host_wdata,
  input  byte_t      host_rdata,
  output logic       prg_32k
);

  dbg_state_e state_q;
  logic       halt_q;
  logic       cfg_32k_q;
  cpu_addr_t  addr_q;               // target address of host cycles
  byte_t      data_q;               // byte for host writes
  logic       bus_wr_q;             // pending cycle is a write
  logic       phase_q;              // second read step, data on or-bus
  logic       wr_accept;
  logic       rd_accept;
  axil_data_t reg_rdata;            // plain register read value

  // aw and w taken together, write wins a tie with ar
  assign wr_accept = (state_q == dbg_idle) && awvalid && wvalid;
  assign rd_accept = (state_q == dbg_idle) && arvalid && !wr_accept;
  assign awready   = wr_accept;
  assign wready    = wr_accept;
  assign arready   = rd_accept;
  assign bresp     = 2'b00;         // always okay
  assign rresp     = 2'b00;

  assign host_active = halt_q;
  assign host_a      = addr_q;      // held for the whole halt
  assign host_wdata  = data_q;
  assign host_r_nw   = !((state_q == dbg_bus) && bus_wr_q); // write strobe one cycle
  assign prg_32k     = cfg_32k_q;

  always_comb begin
    case (araddr)
      dbg_ctrl_off: reg_rdata = {31'd0, halt_q};
      dbg_addr_off: reg_rdata = {16'd0, addr_q};
      dbg_cfg_off:  reg_rdata = {31'd0, cfg_32k_q};
      default:      reg_rdata = 32'd0;  // data reg while running, holes
    endcase
  end

  always_ff @(posedge clk_in) begin
    if (!rst_n) begin
      state_q   <= dbg_idle;
      halt_q    <= 1'b0;
      cfg_32k_q <= 1'b1;            // 32k prg out of reset
      bvalid    <= 1'b0;
      rvalid    <= 1'b0;
      bus_wr_q  <= 1'b0;
      phase_q   <= 1'b0;
    end else begin
      case (state_q)
        dbg_idle: begin
          phase_q <= 1'b0;
          if (wr_accept) begin
            bus_wr_q <= 1'b1;
            if (awaddr == dbg_ctrl_off) halt_q <= wdata[0];
            if (awaddr == dbg_cfg_off) cfg_32k_q <= wdata[0];
            if (awaddr == dbg_data_off && halt_q) begin
              state_q <= dbg_bus;   // b held back until the write is done
            end else begin
              bvalid  <= 1'b1;
              state_q <= dbg_resp;
            end
          end else if (rd_accept) begin
            bus_wr_q <= 1'b0;
            if (araddr == dbg_data_off && halt_q) begin
              state_q <= dbg_bus;
            end else begin
              rvalid  <= 1'b1;      // next cycle for plain regs
              state_q <= dbg_resp;
            end
          end
        end
        dbg_bus: begin
          if (bus_wr_q || phase_q) begin
            bvalid  <= bus_wr_q;
            rvalid  <= !bus_wr_q;   // address, latency, capture
            state_q <= dbg_resp;
          end else begin
            phase_q <= 1'b1;        // memory latency cycle
          end
        end
        dbg_resp: begin
          if ((bvalid && bready) || (rvalid && rready)) begin
            bvalid  <= 1'b0;
            rvalid  <= 1'b0;
            state_q <= dbg_idle;
          end
        end
        default: state_q <= dbg_idle;
      endcase
    end
  end

  always_ff @(posedge clk_in) begin
    if (wr_accept && awaddr == dbg_addr_off) addr_q <= wdata[15:0];
    if (wr_accept && awaddr == dbg_data_off) data_q <= wdata[7:0];
    if (rd_accept) begin
      rdata <= reg_rdata;
    end else if (state_q == dbg_bus && !bus_wr_q && phase_q) begin
      rdata <= {24'd0, host_rdata}; // byte from the or-bus
    end
  end

endmodule

// ==== nes_mem_top.sv ====
`timescale 1ns/100ps

module nes_mem_top import nes_bus_pkg::*; #(
  parameter int PRG_ADDR_BITS = 15  // prg size, 2**n bytes
) (
  input  logic       clk_in,
  input  logic       rst_n,
  input  cpu_addr_t  cpu_a,
  input  logic       cpu_r_nw,
  input  byte_t      cpu_d_out,
  output byte_t      cpu_d_in,
  output logic       cpu_rdy,
  input  axil_addr_t awaddr,
  input  logic       awvalid,
  output logic       awready,
  input  axil_data_t wdata,
  input  logic       wvalid,
  output logic       wready,
  output logic [1:0] bresp,
  output logic       bvalid,
  input  logic       bready,
  input  axil_addr_t araddr,
  input  logic       arvalid,
  output logic       arready,
  output axil_data_t rdata,
  output logic [1:0] rresp,
  output logic       rvalid,
  input  logic       rready
);

  logic      host_active;           // debug halt
  cpu_addr_t host_a;
  logic      host_r_nw;
  byte_t     host_wdata;
  byte_t     host_rdata;
  logic      prg_32k;               // cart mapping config

  cpu_bus_if bus ();

  cpu_mem_map cpu_mem_map_inst (
    .clk_in, .rst_n, .cpu_a, .cpu_r_nw, .cpu_d_out, .cpu_d_in, .cpu_rdy,
    .host_active, .host_a, .host_r_nw, .host_wdata, .host_rdata,
    .bus(bus.mem_map)
  );

  wram wram_inst (.clk_in, .bus(bus.target));

  cart_prg #(.PRG_ADDR_BITS(PRG_ADDR_BITS)) cart_prg_inst (
    .clk_in, .prg_32k, .bus(bus.target)
  );

  dbg_axil_port dbg_axil_port_inst (
    .clk_in, .rst_n, .awaddr, .awvalid, .awready, .wdata, .wvalid, .wready,
    .bresp, .bvalid, .bready, .araddr, .arvalid, .arready, .rdata, .rresp,
    .rvalid, .rready, .host_active, .host_a, .host_r_nw, .host_wdata,
    .host_rdata, .prg_32k
  );

endmodule

// ==== tb_clock_gen.sv ====
`timescale 1ns/100ps

module tb_clock_gen (
  output logic clk_in,
  output logic rst_n
);

  initial begin
    clk_in = 1'b0;
    forever #2 clk_in = ~clk_in;   // 4 ns period
  end

  initial begin
    rst_n = 1'b0;
    repeat (3) @(posedge clk_in);  // sync reset held 3 cycles
    @(negedge clk_in);
    rst_n = 1'b1;
  end

endmodule

// ==== nes_mem_checker.sv ====
`timescale 1ns/100ps

module nes_mem_checker (
  input logic       clk_in,
  input logic       rst_n,
  input logic       cpu_rdy,
  input logic       awvalid,
  input logic       awready,
  input logic       wram_en,
  input logic       cart_en,
  input logic [7:0] bus_rdata,
  input logic       bvalid,
  input logic       bready,
  input logic       rvalid,
  input logic       rready
);

  // cpu stall only moves right after the host writes a register
  rdy_on_write: assert property (@(posedge clk_in) disable iff (!rst_n)
    cpu_rdy != $past(cpu_rdy) |-> $past(awvalid && awready))
    else $error("cpu_rdy changed without an accepted axi write");

  // no target selected last cycle, or-bus reads zero
  unsel_zero: assert property (@(posedge clk_in) disable iff (!rst_n)
    !wram_en && !cart_en |=> bus_rdata == 8'h00)
    else $error("read data not zero after an unmapped access");

  // axi responses held until taken
  b_hold: assert property (@(posedge clk_in) disable iff (!rst_n)
    bvalid && !bready |=> bvalid) else $error("bvalid dropped before bready");

  r_hold: assert property (@(posedge clk_in) disable iff (!rst_n)
    rvalid && !rready |=> rvalid) else $error("rvalid dropped before rready");

endmodule

// top level sees both the cpu bus and the axi port
bind nes_mem_top nes_mem_checker nes_mem_checker_inst (
  .clk_in, .rst_n, .cpu_rdy, .awvalid, .awready,
  .wram_en(bus.wram_en), .cart_en(bus.cart_en), .bus_rdata(bus.rdata),
  .bvalid, .bready, .rvalid, .rready
);

// ==== nes_mem_tb.sv ====
`timescale 1ns/100ps

module nes_mem_tb import nes_bus_pkg::*; ();

  logic       clk_in;
  logic       rst_n;
  cpu_addr_t  cpu_a;
  logic       cpu_r_nw;
  byte_t      cpu_d_out;
  byte_t      cpu_d_in;
  logic       cpu_rdy;
  axil_addr_t awaddr;
  logic       awvalid;
  logic       awready;
  axil_data_t wdata;
  logic       wvalid;
  logic       wready;
  logic [1:0] bresp;
  logic       bvalid;
  logic       bready;
  axil_addr_t araddr;
  logic       arvalid;
  logic       arready;
  axil_data_t rdata;
  logic [1:0] rresp;
  logic       rvalid;
  logic       rready;

  string       names [64];         // pattern table
  string       ports [64];
  string       ops   [64];
  logic [31:0] addrs [64];
  logic [31:0] datas [64];
  logic [31:0] exps  [64];
  int          n_ops = 0;
  logic        loaded = 1'b0;
  string       cur_name = "";
  int          errors = 0;
  int          checks = 0;
  int          test_errs = 0;
  int          n_tests = 0;

  tb_clock_gen tb_clock_gen_inst (.clk_in, .rst_n);

  nes_mem_top nes_mem_top_inst (
    .clk_in, .rst_n, .cpu_a, .cpu_r_nw, .cpu_d_out, .cpu_d_in, .cpu_rdy,
    .awaddr, .awvalid, .awready, .wdata, .wvalid, .wready, .bresp, .bvalid,
    .bready, .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready
  );

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      test_errs++;
      $display("FAILED %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic close_test();
    if (cur_name != "") begin
      n_tests++;
      if (test_errs == 0) $display("test %-10s ok", cur_name);
      else $display("test %-10s %0d mismatches", cur_name, test_errs);
    end
    test_errs = 0;
  endtask

  task automatic cpu_write(input cpu_addr_t a, input byte_t d);
    @(negedge clk_in);
    cpu_a     = a;
    cpu_r_nw  = 1'b0;
    cpu_d_out = d;
    @(negedge clk_in);               // write landed at the edge between
    cpu_r_nw  = 1'b1;
    cpu_a     = 16'h4000;            // park on io, reads zero
  endtask

  task automatic cpu_read(input cpu_addr_t a, output byte_t d);
    @(negedge clk_in);
    cpu_a    = a;
    cpu_r_nw = 1'b1;
    @(negedge clk_in);               // one cycle after the address
    d     = cpu_d_in;
    cpu_a = 16'h4000;
  endtask

  task automatic axi_write(input axil_addr_t off, input axil_data_t d, output logic [1:0] resp);
    @(negedge clk_in);
    awaddr  = off;
    wdata   = d;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    #1;
    while (!(awready && wready)) begin
      @(negedge clk_in);
      #1;
    end
    @(negedge clk_in);               // handshake taken at the edge
    awvalid = 1'b0;
    wvalid  = 1'b0;
    while (!bvalid) @(negedge clk_in);
    resp   = bresp;
    bready = 1'b1;
    @(negedge clk_in);
    bready = 1'b0;
  endtask

  // hold > 0 keeps rready low that many cycles with a competing ar
  task automatic axi_read(input axil_addr_t off, input int hold, output axil_data_t d,
                          output logic [1:0] resp);
    @(negedge clk_in);
    araddr  = off;
    arvalid = 1'b1;
    #1;
    while (!arready) begin
      @(negedge clk_in);
      #1;
    end
    @(negedge clk_in);
    arvalid = 1'b0;
    while (!rvalid) @(negedge clk_in);
    d    = rdata;
    resp = rresp;
    if (hold > 0) begin
      araddr  = dbg_ctrl_off;
      arvalid = 1'b1;                // must not be accepted while r pending
      repeat (hold) begin
        @(negedge clk_in);
        check({cur_name, " rvalid held"}, 32'd1, {31'd0, rvalid});
        check({cur_name, " rdata stable"}, d, rdata);
        check({cur_name, " arready low"}, 32'd0, {31'd0, arready});
      end
      arvalid = 1'b0;
    end
    rready = 1'b1;
    @(negedge clk_in);
    rready = 1'b0;
  endtask

  initial begin
    int    fd;
    int    r;
    string line;
    string nm;
    string pt;
    string op;
    logic [31:0] a;
    logic [31:0] d;
    logic [31:0] e;
    fd = $fopen("nes_mem_patterns.txt", "r");
    if (fd == 0) begin
      $display("cannot open the pattern file nes_mem_patterns.txt");
      $display("Simulation FAILED");
      $finish;
    end else begin
      while (!$feof(fd) && n_ops < 64) begin
        r = $fgets(line, fd);
        if (r > 1 && line.getc(0) != "#") begin
          r = $sscanf(line, "%s %s %s %h %h %h", nm, pt, op, a, d, e);
          if (r == 6) begin
            names[n_ops] = nm;
            ports[n_ops] = pt;
            ops[n_ops]   = op;
            addrs[n_ops] = a;
            datas[n_ops] = d;
            exps[n_ops]  = e;
            n_ops++;
          end
        end
      end
      $fclose(fd);
      loaded = 1'b1;
    end
  end

  // 40 cycles allowed per pattern line
  initial begin
    wait (loaded);
    repeat (n_ops * 40 + 20) @(posedge clk_in);
    $display("watchdog timeout, the patterns did not finish in time");
    $display("Simulation FAILED");
    $finish;
  end

  initial begin
    byte_t      b;
    axil_data_t w;
    logic [1:0] resp;
    cpu_a     = 16'h4000;
    cpu_r_nw  = 1'b1;
    cpu_d_out = 8'h00;
    awaddr    = '0;
    awvalid   = 1'b0;
    wdata     = '0;
    wvalid    = 1'b0;
    bready    = 1'b0;
    araddr    = '0;
    arvalid   = 1'b0;
    rready    = 1'b0;
    wait (loaded);
    wait (rst_n);
    for (int i = 0; i < n_ops; i++) begin
      if (names[i] != cur_name) begin
        close_test();
        cur_name = names[i];
      end
      if (ports[i] == "cpu" && ops[i] == "wr") begin
        cpu_write(addrs[i][15:0], datas[i][7:0]);
      end else if (ports[i] == "cpu" && ops[i] == "rd") begin
        cpu_read(addrs[i][15:0], b);
        check(cur_name, exps[i], {24'd0, b});
      end else if (ports[i] == "cpu" && ops[i] == "rdy") begin
        @(negedge clk_in);
        check({cur_name, " cpu_rdy"}, exps[i], {31'd0, cpu_rdy});
      end else if (ports[i] == "axi" && ops[i] == "wr") begin
        axi_write(addrs[i][3:0], datas[i], resp);
        check({cur_name, " bresp"}, 32'd0, {30'd0, resp});
      end else if (ports[i] == "axi" && (ops[i] == "rd" || ops[i] == "bp")) begin
        axi_read(addrs[i][3:0], (ops[i] == "bp") ? int'(datas[i]) : 0, w, resp);
        check(cur_name, exps[i], w);
        check({cur_name, " rresp"}, 32'd0, {30'd0, resp});
      end else begin
        errors++;
        $display("unknown operation %s %s on pattern line %0d", ports[i], ops[i], i);
      end
    end
    close_test();
    $display("%0d tests, %0d checks, %0d errors", n_tests, checks, errors);
    if (errors == 0 && n_ops > 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

// ==== nes_mem_patterns.txt ====
# test port op addr data expected (hex); axi addr is the register offset
# ops: cpu wr/rd/rdy, axi wr/rd, axi bp holds rready low for data cycles
reset      cpu rdy 0    0    1
reset      axi rd  0    0    0
wram       cpu wr  0123 a5   0
wram       cpu rd  0123 0    a5
wram       cpu rd  1923 0    a5
load       axi wr  0    1    0
load       cpu rdy 0    0    0
load       axi wr  4    8000 0
load       axi wr  8    3c   0
load       axi wr  4    c000 0
load       axi wr  8    c3   0
load       axi wr  4    8000 0
load       axi rd  8    0    3c
load       axi wr  4    c000 0
load       axi rd  8    0    c3
load       axi wr  4    2002 0
load       axi rd  8    0    0
protect    axi wr  0    0    0
protect    cpu rdy 0    0    1
protect    cpu wr  8000 55   0
protect    cpu rd  8000 0    3c
map16k     axi wr  c    0    0
map16k     axi rd  c    0    0
map16k     cpu rd  c000 0    3c
backpress  axi wr  0    1    0
backpress  axi wr  4    8000 0
backpress  axi bp  8    5    3c
backpress  axi rd  0    0    1

// ==== build.f ====
nes_bus_pkg.sv
cpu_bus_if.sv
cpu_mem_map.sv
wram.sv
cart_prg.sv
dbg_axil_port.sv
nes_mem_top.sv
tb_clock_gen.sv
nes_mem_checker.sv
nes_mem_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# compile and run the nes memory testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f build.f --top-module nes_mem_tb -o nes_mem_sim
if [ $? -ne 0 ]; then
  echo "verilator compile failed"
  exit 1
fi

./obj_dir/nes_mem_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Simulation FAILED" "$LOG"; then
  exit 1
fi
if ! grep -q "Simulation PASSED" "$LOG"; then
  echo "no result line in $LOG"
  exit 1
fi
exit 0
